/* isaPkg.sv */
`default_nettype none

package isaPkg;

    typedef logic [6:0] instrId;

    // ids with a name; 1 to 66 and 73 are numbered in the decoder
    localparam instrId IdPush   = 7'd67;
    localparam instrId IdPop    = 7'd68;
    localparam instrId IdOutput = 7'd69;
    localparam instrId IdPause  = 7'd70;
    localparam instrId IdInput  = 7'd71;
    localparam instrId IdSwi    = 7'd72;
    localparam instrId IdNop    = 7'd74;
    localparam instrId IdHalt   = 7'd75;

    typedef logic [3:0] aluOp;

    localparam aluOp AluPassA = 4'd0;
    localparam aluOp AluAnd   = 4'd1;
    localparam aluOp AluAdd   = 4'd2;
    localparam aluOp AluCmp   = 4'd3;  // sub, compare form
    localparam aluOp AluCmn   = 4'd4;
    localparam aluOp AluSub   = 4'd5;
    localparam aluOp AluEor   = 4'd6;
    localparam aluOp AluOrr   = 4'd7;
    localparam aluOp AluBic   = 4'd8;
    localparam aluOp AluTst   = 4'd9;
    localparam aluOp AluMul   = 4'd10;
    localparam aluOp AluMvn   = 4'd11;
    localparam aluOp AluPassB = 4'd12;
    localparam aluOp AluAdc   = 4'd13;
    localparam aluOp AluSbc   = 4'd14;

    typedef logic [3:0] shiftOp;

    localparam shiftOp ShNone  = 4'd0;
    localparam shiftOp ShPassB = 4'd1;
    localparam shiftOp ShAsr   = 4'd2;
    localparam shiftOp ShLsl   = 4'd3;
    localparam shiftOp ShLsr   = 4'd4;
    localparam shiftOp ShRor   = 4'd5;
    localparam shiftOp ShSxtb  = 4'd6;
    localparam shiftOp ShSxth  = 4'd7;
    localparam shiftOp ShRev   = 4'd8;

    typedef logic [2:0] flagMode;

    localparam flagMode FlagHold    = 3'd0;
    localparam flagMode FlagShift   = 3'd1;  // nzc, shifter carry
    localparam flagMode FlagAluNzcv = 3'd2;
    localparam flagMode FlagAluNz   = 3'd3;
    localparam flagMode FlagAluNzc  = 3'd4;

    // channel b and load extension share this encoding
    typedef logic [2:0] extMode;

    localparam extMode ExtNone     = 3'd0;
    localparam extMode ExtSign8    = 3'd1;
    localparam extMode ExtSign11x2 = 3'd2;
    localparam extMode ExtZero8    = 3'd3;
    localparam extMode ExtZero5    = 3'd4;

    typedef logic [2:0] regBankCtrl;
    typedef logic [2:0] memAddrCtrl;

endpackage

`default_nettype wire

/* datapathPkg.sv */
`default_nettype none

package datapathPkg;

    localparam int DataWidth = 32;

    typedef logic [DataWidth-1:0] dataWord;

    typedef struct packed {
        logic N;
        logic Z;
        logic C;  // set means no borrow on subtract
        logic V;
    } statusFlags;

endpackage

`default_nettype wire

/* ControlCore.sv */
`timescale 1ns/1ps
`default_nettype none

module ControlCore (
    input  isaPkg::instrId     instr,
    input  logic               mode,
    input  logic               confirmation,
    input  logic               resume,
    output isaPkg::aluOp       aluCtrl,
    output isaPkg::shiftOp     shiftCtrl,
    output isaPkg::flagMode    flagCtrl,
    output isaPkg::extMode     bExtCtrl,
    output isaPkg::extMode     loadExtSel,
    output isaPkg::regBankCtrl regBankSel,
    output isaPkg::memAddrCtrl memAddrSel,
    output logic               useOffset,
    output logic               memWrite,
    output logic               readInput,
    output logic               isInput,
    output logic               isOutput,
    output logic               stallFree
);
    import isaPkg::*;

    always_comb begin
        aluCtrl    = AluPassB;
        shiftCtrl  = ShNone;
        flagCtrl   = FlagHold;
        bExtCtrl   = ExtNone;
        loadExtSel = ExtNone;
        regBankSel = 3'd0;
        memAddrSel = 3'd0;
        useOffset  = 1'b0;
        memWrite   = 1'b0;
        readInput  = 1'b0;
        isInput    = 1'b0;
        isOutput   = 1'b0;
        stallFree  = 1'b1;

        case (instr) inside
            4, 6, 10, 23, 28, 29, 30, [39:57], 73: aluCtrl = AluAdd;
            5, 7, 9, 11, 22, 31, 32, 33:           aluCtrl = AluSub;
            12:                                    aluCtrl = AluCmp;
            13:                                    aluCtrl = AluAdc;
            17:                                    aluCtrl = AluAnd;
            18:                                    aluCtrl = AluBic;
            20:                                    aluCtrl = AluSbc;
            21:                                    aluCtrl = AluEor;
            24:                                    aluCtrl = AluOrr;
            25:                                    aluCtrl = AluTst;
            26:                                    aluCtrl = AluCmn;
            34:                                    aluCtrl = AluMul;
            65:                                    aluCtrl = AluMvn;
            IdOutput, IdInput:                     aluCtrl = AluPassA;
            default:                               aluCtrl = AluPassB;
        endcase

        case (instr) inside
            1, 14:   shiftCtrl = ShLsl;
            2, 15:   shiftCtrl = ShLsr;
            3, 16:   shiftCtrl = ShAsr;
            19:      shiftCtrl = ShRor;
            39:      shiftCtrl = ShPassB;  // pc-relative address via b
            63:      shiftCtrl = ShSxtb;
            64:      shiftCtrl = ShSxth;
            66:      shiftCtrl = ShRev;
            default: shiftCtrl = ShNone;
        endcase

        case (instr) inside
            [1:3], 14, 15, 16, 19:                           flagCtrl = FlagShift;
            [4:7], [9:11], 13, 20, 22, 23, [31:33]:          flagCtrl = FlagAluNzcv;
            8, 12, 17, 18, 21, [24:27]:                      flagCtrl = FlagAluNz;
            34, 65:                                          flagCtrl = FlagAluNzc;
            default:                                         flagCtrl = FlagHold;
        endcase

        case (instr) inside
            [1:3], [6:11], 39, [48:57], 73: useOffset = 1'b1;
            IdSwi:                          useOffset = !mode;  // user mode takes the vector
            default:                        useOffset = 1'b0;
        endcase

        case (instr) inside
            54, 55, 60, 73: bExtCtrl = ExtSign11x2;
            59:             bExtCtrl = ExtSign8;
            61:             bExtCtrl = ExtZero8;
            62:             bExtCtrl = ExtZero5;
            default:        bExtCtrl = ExtNone;
        endcase

        // load side
        case (instr) inside
            47:                 loadExtSel = ExtSign8;
            43:                 loadExtSel = ExtSign11x2;
            45, 53, IdInput:    loadExtSel = ExtZero8;
            46, 51:             loadExtSel = ExtZero5;
            default:            loadExtSel = ExtNone;
        endcase

        case (instr) inside
            IdPush:                     memAddrSel = 3'd1;
            IdPop:                      memAddrSel = 3'd2;
            42, 43, 46, 50, 51:         memAddrSel = 3'd3;
            41, 45, 47, 52, 53:         memAddrSel = 3'd4;
            39, 40, 44, 48, 49, 54, 55: memAddrSel = 3'd5;
            default:                    memAddrSel = 3'd0;
        endcase

        case (instr) inside
            40, 41, 42, 48, 50, 52, 54, IdPush: memWrite = 1'b1;
            default:                            memWrite = 1'b0;
        endcase

        case (instr) inside
            [1:8], [10:21], [24:29], 31, [34:37], 56, 57, [59:66]:
                regBankSel = 3'd1;
            39, 43, 44, 45, 46, 47, 49, 51, 53, 55, IdPop, IdInput:
                regBankSel = 3'd3;
            58:
                regBankSel = 3'd2;
            IdSwi:
                regBankSel = mode ? 3'd0 : 3'd4;
            default:
                regBankSel = 3'd0;
        endcase

        // handshake group
        case (instr)
            IdOutput: begin
                isOutput  = 1'b1;
                stallFree = confirmation;
            end
            IdPause: begin
                isInput   = 1'b1;
                isOutput  = 1'b1;
                stallFree = resume;
            end
            IdInput: begin
                isInput   = 1'b1;
                readInput = 1'b1;
                stallFree = confirmation;
            end
            IdHalt:  stallFree = 1'b0;
            default: stallFree = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* ChannelBExtend.sv */
`timescale 1ns/1ps
`default_nettype none

module ChannelBExtend (
    input  datapathPkg::dataWord operandB,
    input  datapathPkg::dataWord offset,
    input  logic                 useOffset,
    input  isaPkg::extMode       bExtCtrl,
    output datapathPkg::dataWord channelB
);
    import isaPkg::*;
    import datapathPkg::*;

    dataWord source;

    assign source = useOffset ? offset : operandB;

    always_comb begin
        case (bExtCtrl)
            ExtSign8:    channelB = {{(DataWidth-8){source[7]}}, source[7:0]};
            ExtSign11x2: channelB = {{(DataWidth-12){source[10]}}, source[10:0], 1'b0};
            ExtZero8:    channelB = {{(DataWidth-8){1'b0}}, source[7:0]};
            ExtZero5:    channelB = {{(DataWidth-5){1'b0}}, source[4:0]};
            default:     channelB = source;
        endcase
    end

endmodule

`default_nettype wire

/* AluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module AluUnit (
    input  datapathPkg::dataWord opA,
    input  datapathPkg::dataWord opB,
    input  isaPkg::aluOp         aluCtrl,
    input  logic                 carryIn,
    output datapathPkg::dataWord aluResult,
    output logic                 aluCarry,
    output logic                 aluOverflow
);
    import isaPkg::*;
    import datapathPkg::*;

    logic               isSub;
    logic               isArith;
    logic               addCin;
    dataWord            addB;
    logic [DataWidth:0] sum;  // top bit is carry out

    assign isSub   = aluCtrl inside {AluCmp, AluSub, AluSbc};
    assign isArith = aluCtrl inside {AluAdd, AluCmp, AluCmn, AluSub, AluAdc, AluSbc};
    assign addB    = isSub ? ~opB : opB;

    always_comb begin
        case (aluCtrl)
            AluAdc, AluSbc: addCin = carryIn;
            AluCmp, AluSub: addCin = 1'b1;
            default:        addCin = 1'b0;
        endcase
    end

    // one adder for all add and subtract forms
    assign sum = {1'b0, opA} + {1'b0, addB} + {{DataWidth{1'b0}}, addCin};

    always_comb begin
        case (aluCtrl)
            AluPassA: aluResult = opA;
            AluAnd,
            AluTst:   aluResult = opA & opB;
            AluAdd,
            AluCmp,
            AluCmn,
            AluSub,
            AluAdc,
            AluSbc:   aluResult = sum[DataWidth-1:0];
            AluEor:   aluResult = opA ^ opB;
            AluOrr:   aluResult = opA | opB;
            AluBic:   aluResult = opA & ~opB;
            AluMul:   aluResult = opA * opB;  // low word only
            AluMvn:   aluResult = ~opB;
            default:  aluResult = opB;
        endcase
    end

    assign aluCarry    = isArith ? sum[DataWidth] : carryIn;
    // operands agree in sign, result does not
    assign aluOverflow = isArith && (opA[DataWidth-1] == addB[DataWidth-1])
                         && (sum[DataWidth-1] != opA[DataWidth-1]);

endmodule

`default_nettype wire

/* ShiftUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module ShiftUnit (
    input  datapathPkg::dataWord opA,
    input  logic [4:0]           amount,
    input  datapathPkg::dataWord opB,
    input  isaPkg::shiftOp       shiftCtrl,
    input  logic                 carryIn,
    output datapathPkg::dataWord shiftResult,
    output logic                 shiftCarry
);
    import isaPkg::*;
    import datapathPkg::*;

    logic [DataWidth:0]        lslWide;  // {carry, word}
    logic [DataWidth:0]        lsrWide;  // {word, carry}
    logic signed [DataWidth:0] asrWide;
    dataWord                   rorWord;

    assign lslWide = {1'b0, opA} << amount;
    assign lsrWide = {opA, 1'b0} >> amount;
    assign asrWide = $signed({opA, 1'b0}) >>> amount;
    assign rorWord = dataWord'({opA, opA} >> amount);

    always_comb begin
        case (shiftCtrl)
            ShLsl:   shiftResult = lslWide[DataWidth-1:0];
            ShLsr:   shiftResult = lsrWide[DataWidth:1];
            ShAsr:   shiftResult = asrWide[DataWidth:1];
            ShRor:   shiftResult = rorWord;
            ShPassB: shiftResult = opB;
            ShSxtb:  shiftResult = {{(DataWidth-8){opB[7]}}, opB[7:0]};
            ShSxth:  shiftResult = {{(DataWidth-16){opB[15]}}, opB[15:0]};
            ShRev:   shiftResult = {opB[7:0], opB[15:8], opB[23:16], opB[31:24]};
            default: shiftResult = opA;
        endcase
    end

    // last bit out; no shift keeps the stored carry
    always_comb begin
        case (shiftCtrl)
            ShLsl:   shiftCarry = lslWide[DataWidth];
            ShLsr:   shiftCarry = lsrWide[0];
            ShAsr:   shiftCarry = asrWide[0];
            ShRor:   shiftCarry = rorWord[DataWidth-1];
            default: shiftCarry = carryIn;
        endcase
        if (amount == 5'd0)
            shiftCarry = carryIn;
    end

endmodule

`default_nettype wire

/* FlagResultMerge.sv */
`timescale 1ns/1ps
`default_nettype none

module FlagResultMerge (
    input  logic                    clk,
    input  logic                    rstN,
    input  datapathPkg::dataWord    aluResult,
    input  logic                    aluCarry,
    input  logic                    aluOverflow,
    input  datapathPkg::dataWord    shiftResult,
    input  logic                    shiftCarry,
    input  isaPkg::shiftOp          shiftCtrl,
    input  isaPkg::flagMode         flagCtrl,
    input  logic                    stallFree,
    input  logic                    isInput,
    input  logic                    isOutput,
    output datapathPkg::dataWord    result,
    output datapathPkg::statusFlags flags,
    output logic                    running
);
    import isaPkg::*;
    import datapathPkg::*;

    dataWord    chosen;
    statusFlags nextFlags;
    logic       haltSeen;

    assign chosen   = (shiftCtrl != ShNone) ? shiftResult : aluResult;
    // stall with no handshake pending means halt
    assign haltSeen = !stallFree && !isInput && !isOutput;

    always_comb begin
        nextFlags = flags;
        if (flagCtrl != FlagHold) begin
            nextFlags.N = chosen[DataWidth-1];
            nextFlags.Z = (chosen == '0);
        end
        case (flagCtrl)
            FlagShift:   nextFlags.C = shiftCarry;
            FlagAluNzcv: begin
                nextFlags.C = aluCarry;
                nextFlags.V = aluOverflow;
            end
            FlagAluNzc:  nextFlags.C = aluCarry;
            default: ;  // nz only, or hold
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            result  <= '0;
            flags   <= '0;
            running <= 1'b1;
        end else if (running) begin
            if (stallFree) begin
                result <= chosen;
                flags  <= nextFlags;
            end
            if (haltSeen)
                running <= 1'b0;  // only reset restarts
        end
    end

endmodule

`default_nettype wire

/* ExecuteCore.sv */
`timescale 1ns/1ps
`default_nettype none

module ExecuteCore (
    input  logic                    clk,
    input  logic                    rstN,
    input  isaPkg::instrId          instr,
    input  datapathPkg::dataWord    operandA,
    input  datapathPkg::dataWord    operandB,
    input  datapathPkg::dataWord    offset,
    input  logic                    mode,
    input  logic                    confirmation,
    input  logic                    resume,
    output datapathPkg::dataWord    result,
    output datapathPkg::statusFlags flags,
    output logic                    running,
    output isaPkg::regBankCtrl      regBankSel,
    output isaPkg::memAddrCtrl      memAddrSel,
    output isaPkg::extMode          loadExtSel,
    output logic                    memWrite,
    output logic                    readInput,
    output logic                    isInput,
    output logic                    isOutput
);
    import isaPkg::*;
    import datapathPkg::*;

    aluOp    aluCtrl;
    shiftOp  shiftCtrl;
    flagMode flagCtrl;
    extMode  bExtCtrl;
    logic    useOffset;
    logic    stallFree;
    dataWord channelB;
    dataWord aluResult;
    logic    aluCarry;
    logic    aluOverflow;
    dataWord shiftResult;
    logic    shiftCarry;

    ControlCore i_control (
        .instr(instr), .mode(mode), .confirmation(confirmation), .resume(resume),
        .aluCtrl(aluCtrl), .shiftCtrl(shiftCtrl), .flagCtrl(flagCtrl),
        .bExtCtrl(bExtCtrl), .loadExtSel(loadExtSel), .regBankSel(regBankSel),
        .memAddrSel(memAddrSel), .useOffset(useOffset), .memWrite(memWrite),
        .readInput(readInput), .isInput(isInput), .isOutput(isOutput),
        .stallFree(stallFree)
    );

    ChannelBExtend i_channelB (
        .operandB(operandB), .offset(offset), .useOffset(useOffset),
        .bExtCtrl(bExtCtrl), .channelB(channelB)
    );

    AluUnit i_alu (
        .opA(operandA), .opB(channelB), .aluCtrl(aluCtrl), .carryIn(flags.C),
        .aluResult(aluResult), .aluCarry(aluCarry), .aluOverflow(aluOverflow)
    );

    // shift amount rides in the low bits of channel b
    ShiftUnit i_shift (
        .opA(operandA), .amount(channelB[4:0]), .opB(channelB),
        .shiftCtrl(shiftCtrl), .carryIn(flags.C),
        .shiftResult(shiftResult), .shiftCarry(shiftCarry)
    );

    FlagResultMerge i_merge (
        .clk(clk), .rstN(rstN), .aluResult(aluResult), .aluCarry(aluCarry),
        .aluOverflow(aluOverflow), .shiftResult(shiftResult), .shiftCarry(shiftCarry),
        .shiftCtrl(shiftCtrl), .flagCtrl(flagCtrl), .stallFree(stallFree),
        .isInput(isInput), .isOutput(isOutput),
        .result(result), .flags(flags), .running(running)
    );

endmodule

`default_nettype wire

/* executeCore_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module executeCoreProperties (
    input logic                 clk,
    input logic                 rstN,
    input isaPkg::instrId       instr,
    input datapathPkg::dataWord result,
    input logic                 running,
    input logic                 memWrite,
    input logic                 readInput,
    input logic                 isInput,
    input logic                 stallFree,
    input logic                 confirmation,
    input logic                 resume
);
    import isaPkg::*;

    // halted core freezes its result
    haltedHoldsResult: assert property (@(posedge clk) disable iff (!rstN)
        !running |=> $stable(result))
        else $error("result changed while the core was halted");

    haltStopsCore: assert property (@(posedge clk) disable iff (!rstN)
        instr == IdHalt |=> !running)
        else $error("running still high one cycle after HALT");

    noWriteOnRead: assert property (@(posedge clk) disable iff (!rstN)
        !(memWrite && readInput))
        else $error("memory write and input read decoded together");

    inputStallHasCause: assert property (@(posedge clk) disable iff (!rstN)
        (!stallFree && isInput) |-> (!confirmation || !resume))
        else $error("input stall with both handshake lines high");

endmodule

bind ExecuteCore executeCoreProperties i_props (
    .clk(clk), .rstN(rstN), .instr(instr), .result(result), .running(running),
    .memWrite(memWrite), .readInput(readInput), .isInput(isInput),
    .stallFree(stallFree), .confirmation(confirmation), .resume(resume)
);

`default_nettype wire

/* tbExecuteCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tbExecuteCore;
    import isaPkg::*;
    import datapathPkg::*;

    localparam int ClkPeriod   = 20;
    localparam int ResetCycles = 16;

    typedef struct {
        string      name;
        instrId     instr;
        dataWord    a;
        dataWord    b;
        dataWord    off;
        logic       mode;
        logic       conf;
        logic       resume;
        dataWord    expResult;
        statusFlags expFlags;
        regBankCtrl expRegBank;
        memAddrCtrl expMemAddr;
        extMode     expLoadExt;
        logic       expMemWrite;
        logic [2:0] expIo;
        logic       expRunning;
    } rowEntry;

    logic       clk;
    logic       rstN;
    instrId     instr;
    dataWord    operandA;
    dataWord    operandB;
    dataWord    offset;
    logic       mode;
    logic       confirmation;
    logic       resume;
    dataWord    result;
    statusFlags flags;
    logic       running;
    regBankCtrl regBankSel;
    memAddrCtrl memAddrSel;
    extMode     loadExtSel;
    logic       memWrite;
    logic       readInput;
    logic       isInput;
    logic       isOutput;
    rowEntry    rows[$];
    logic       tableBuilt;
    integer     seed;

    ExecuteCore i_dut (
        .clk(clk), .rstN(rstN), .instr(instr), .operandA(operandA), .operandB(operandB),
        .offset(offset), .mode(mode), .confirmation(confirmation), .resume(resume),
        .result(result), .flags(flags), .running(running), .regBankSel(regBankSel),
        .memAddrSel(memAddrSel), .loadExtSel(loadExtSel), .memWrite(memWrite),
        .readInput(readInput), .isInput(isInput), .isOutput(isOutput)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input dataWord exp, input dataWord act);
        if (act !== exp)
            reportFailure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic checkFlags(input string name, input statusFlags exp, input statusFlags act);
        if (act !== exp)
            reportFailure($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic checkCode(input string name, input regBankCtrl exp, input regBankCtrl act);
        if (act !== exp)
            reportFailure($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp)
            reportFailure($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic addRow(input string name, input int id, input dataWord a, input dataWord b,
                          input dataWord off, input int md, input int cf, input int rs,
                          input dataWord expR, input int fl, input int rb, input int ma,
                          input int le, input int mw, input int io, input int run);
        rowEntry r;
        r.name = name;
        r.instr = id[6:0];
        r.a = a;
        r.b = b;
        r.off = off;
        r.mode = md[0];
        r.conf = cf[0];
        r.resume = rs[0];
        r.expResult = expR;
        r.expFlags = fl[3:0];
        r.expRegBank = rb[2:0];
        r.expMemAddr = ma[2:0];
        r.expLoadExt = le[2:0];
        r.expMemWrite = mw[0];
        r.expIo = io[2:0];
        r.expRunning = run[0];
        rows.push_back(r);
    endtask

    // expected word and NZCV from plain two's-complement arithmetic
    task automatic addRandomRow(input string name, input logic isSub);
        dataWord     a;
        dataWord     b;
        logic [32:0] wide;
        statusFlags  f;
        a = $random(seed);
        b = $random(seed);
        if (isSub) begin
            wide = {1'b0, a} - {1'b0, b};
            f.C = (a >= b);  // no borrow
            f.V = (a[31] != b[31]) && (wide[31] != a[31]);
        end else begin
            wide = {1'b0, a} + {1'b0, b};
            f.C = wide[32];
            f.V = (a[31] == b[31]) && (wide[31] != a[31]);
        end
        f.N = wide[31];
        f.Z = (wide[31:0] == 32'h0);
        addRow(name, isSub ? 5 : 4, a, b, 'h0, 0, 1, 1, wide[31:0], int'(f), 1, 0, 0, 0, 0, 1);
    endtask

    // name, id, a, b, offset, mode, conf, resume,
    // result, NZCV, regBank, memAddr, loadExt, mw, io {readInput, isInput, isOutput}, run
    task automatic buildTable();
        addRow("add", 4, 'h5, 'h3, 'h0, 0, 1, 1, 'h8, 'b0000, 1, 0, 0, 0, 0, 1);
        addRow("sub_neg", 5, 'h3, 'h5, 'h0, 0, 1, 1, 'hFFFFFFFE, 'b1000, 1, 0, 0, 0, 0, 1);
        addRow("sub_zero", 5, 'h7, 'h7, 'h0, 0, 1, 1, 'h0, 'b0110, 1, 0, 0, 0, 0, 1);
        addRow("adc", 13, 'hA, 'h14, 'h0, 0, 1, 1, 'h1F, 'b0000, 1, 0, 0, 0, 0, 1);
        addRow("sbc", 20, 'hA, 'h3, 'h0, 0, 1, 1, 'h6, 'b0010, 1, 0, 0, 0, 0, 1);
        addRow("add_ovf", 4, 'h7FFFFFFF, 'h1, 'h0, 0, 1, 1, 'h80000000, 'b1001, 1, 0, 0, 0, 0, 1);
        addRow("sub_ovf", 5, 'h80000000, 'h1, 'h0, 0, 1, 1, 'h7FFFFFFF, 'b0011, 1, 0, 0, 0, 0, 1);
        addRow("orr", 24, 'hF0, 'hF, 'h0, 0, 1, 1, 'hFF, 'b0011, 1, 0, 0, 0, 0, 1);
        addRow("mvn", 65, 'h0, 'h0, 'h0, 0, 1, 1, 'hFFFFFFFF, 'b1011, 1, 0, 0, 0, 0, 1);
        addRow("and", 17, 'hF0, 'hF, 'h0, 0, 1, 1, 'h0, 'b0111, 1, 0, 0, 0, 0, 1);
        addRow("eor", 21, 'hFF00FF00, 'hFFFF, 'h0, 0, 1, 1, 'hFF0000FF, 'b1011, 1, 0, 0, 0, 0, 1);
        addRow("bic", 18, 'h80000001, 'h1, 'h0, 0, 1, 1, 'h80000000, 'b1011, 1, 0, 0, 0, 0, 1);
        addRandomRow("add_rand", 1'b0);
        addRandomRow("sub_rand", 1'b1);
        addRow("add_clear", 4, 'hFFFFFFFF, 'h1, 'h0, 0, 1, 1, 'h0, 'b0110, 1, 0, 0, 0, 0, 1);
        addRow("lsl_imm", 1, 'h80000001, 'h0, 'h1, 0, 1, 1, 'h2, 'b0010, 1, 0, 0, 0, 0, 1);
        addRow("lsr_reg", 15, 'h3, 'h1, 'h0, 0, 1, 1, 'h1, 'b0010, 1, 0, 0, 0, 0, 1);
        addRow("asr_imm", 3, 'h80000000, 'h0, 'h4, 0, 1, 1, 'hF8000000, 'b1000, 1, 0, 0, 0, 0, 1);
        addRow("ror_reg", 19, 'h1, 'h1, 'h0, 0, 1, 1, 'h80000000, 'b1010, 1, 0, 0, 0, 0, 1);
        addRow("lsl_zero", 14, 'h5, 'h0, 'h0, 0, 1, 1, 'h5, 'b0010, 1, 0, 0, 0, 0, 1);
        addRow("sxtb", 63, 'h0, 'h1280, 'h0, 0, 1, 1, 'hFFFFFF80, 'b0010, 1, 0, 0, 0, 0, 1);
        addRow("sxth", 64, 'h0, 'h18001, 'h0, 0, 1, 1, 'hFFFF8001, 'b0010, 1, 0, 0, 0, 0, 1);
        addRow("rev", 66, 'h0, 'h11223344, 'h0, 0, 1, 1, 'h44332211, 'b0010, 1, 0, 0, 0, 0, 1);
        addRow("mov_imm", 8, 'h0, 'hDEAD, 'h0, 0, 1, 1, 'h0, 'b0110, 1, 0, 0, 0, 0, 1);
        addRow("add_imm", 6, 'h80000000, 'hD, 'h5, 0, 1, 1, 'h80000005, 'b1000, 1, 0, 0, 0, 0, 1);
        addRow("add_sx11", 73, 'h1000, 'h0, 'hF403, 0, 1, 1, 'h806, 'b1000, 0, 0, 0, 0, 0, 1);
        addRow("sxtb_b", 59, 'h0, 'hF0, 'h0, 0, 1, 1, 'hFFFFFFF0, 'b1000, 1, 0, 0, 0, 0, 1);
        addRow("zext5", 62, 'h0, 'hFFFFFFFF, 'h0, 0, 1, 1, 'h1F, 'b1000, 1, 0, 0, 0, 0, 1);
        addRow("str_off", 54, 'h200, 'h0, 'h5, 0, 1, 1, 'h20A, 'b1000, 0, 5, 0, 1, 0, 1);
        addRow("str_reg", 40, 'h100, 'h4, 'h0, 0, 1, 1, 'h104, 'b1000, 0, 5, 0, 1, 0, 1);
        addRow("ldrsb", 47, 'h100, 'h8, 'h0, 0, 1, 1, 'h108, 'b1000, 3, 4, 1, 0, 0, 1);
        addRow("ld_x11", 43, 'h100, 'hC, 'h0, 0, 1, 1, 'h10C, 'b1000, 3, 3, 2, 0, 0, 1);
        addRow("ldrb", 45, 'h100, 'h10, 'h0, 0, 1, 1, 'h110, 'b1000, 3, 4, 3, 0, 0, 1);
        addRow("push", 67, 'h0, 'h44, 'h0, 0, 1, 1, 'h44, 'b1000, 0, 1, 0, 1, 0, 1);
        addRow("pop", 68, 'h0, 'h48, 'h0, 0, 1, 1, 'h48, 'b1000, 3, 2, 0, 0, 0, 1);
        addRow("swi_user", 72, 'h0, 'h0, 'h8, 0, 1, 1, 'h8, 'b1000, 4, 0, 0, 0, 0, 1);
        addRow("swi_priv", 72, 'h0, 'hC, 'h8, 1, 1, 1, 'hC, 'b1000, 0, 0, 0, 0, 0, 1);
        addRow("out_wait", 69, 'hABCD, 'h0, 'h0, 0, 0, 1, 'hC, 'b1000, 0, 0, 0, 0, 'b001, 1);
        addRow("out_wait2", 69, 'hABCD, 'h0, 'h0, 0, 0, 1, 'hC, 'b1000, 0, 0, 0, 0, 'b001, 1);
        addRow("out_go", 69, 'hABCD, 'h0, 'h0, 0, 1, 1, 'hABCD, 'b1000, 0, 0, 0, 0, 'b001, 1);
        addRow("in_wait", 71, 'h1234, 'h0, 'h0, 0, 0, 1, 'hABCD, 'b1000, 3, 0, 3, 0, 'b110, 1);
        addRow("in_go", 71, 'h1234, 'h0, 'h0, 0, 1, 1, 'h1234, 'b1000, 3, 0, 3, 0, 'b110, 1);
        addRow("pause_wait", 70, 'h0, 'h5678, 'h0, 0, 1, 0, 'h1234, 'b1000, 0, 0, 0, 0, 'b011, 1);
        addRow("pause_go", 70, 'h0, 'h5678, 'h0, 0, 1, 1, 'h5678, 'b1000, 0, 0, 0, 0, 'b011, 1);
        addRow("halt", 75, 'h0, 'h0, 'h0, 0, 1, 1, 'h5678, 'b1000, 0, 0, 0, 0, 0, 0);
        addRow("after_halt", 4, 'hFFFFFFFF, 'h1, 'h0, 0, 1, 1, 'h5678, 'b1000, 1, 0, 0, 0, 0, 0);
        addRow("after_halt2", 5, 'h3, 'h5, 'h0, 0, 1, 1, 'h5678, 'b1000, 1, 0, 0, 0, 0, 0);
    endtask

    initial begin
        wait (tableBuilt);
        #((rows.size() * 4 + ResetCycles) * ClkPeriod);
        reportFailure("Timeout: the testbench did not reach its end in time");
    end

    initial begin
        rowEntry r;
        rstN = 1'b0;
        instr = IdNop;
        operandA = '0;
        operandB = '0;  // nop passes b into result
        offset = '0;
        mode = 1'b0;
        confirmation = 1'b0;
        resume = 1'b0;
        seed = 6;
        tableBuilt = 1'b0;
        buildTable();
        tableBuilt = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #2 rstN = 1'b1;
        foreach (rows[i]) begin
            r = rows[i];
            instr = r.instr;
            operandA = r.a;
            operandB = r.b;
            offset = r.off;
            mode = r.mode;
            confirmation = r.conf;
            resume = r.resume;
            #1;
            checkCode({r.name, " regBankSel"}, r.expRegBank, regBankSel);
            checkCode({r.name, " memAddrSel"}, r.expMemAddr, memAddrSel);
            checkCode({r.name, " loadExtSel"}, r.expLoadExt, loadExtSel);
            checkBit({r.name, " memWrite"}, r.expMemWrite, memWrite);
            checkBit({r.name, " readInput"}, r.expIo[2], readInput);
            checkBit({r.name, " isInput"}, r.expIo[1], isInput);
            checkBit({r.name, " isOutput"}, r.expIo[0], isOutput);
            @(posedge clk);
            #1;  // registered outputs settled
            checkWord({r.name, " result"}, r.expResult, result);
            checkFlags({r.name, " flags"}, r.expFlags, flags);
            checkBit({r.name, " running"}, r.expRunning, running);
            #1;
        end
        // only reset restarts a halted core
        rstN = 1'b0;
        @(posedge clk);
        #1;
        checkWord("reset result", '0, result);
        checkFlags("reset flags", '0, flags);
        checkBit("reset running", 1'b1, running);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
isaPkg.sv
datapathPkg.sv
ControlCore.sv
ChannelBExtend.sv
AluUnit.sv
ShiftUnit.sv
FlagResultMerge.sv
ExecuteCore.sv
executeCore_properties.sv
tbExecuteCore.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= tbExecuteCore
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
